// ==== src/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

`define RV_XLEN         32
`define RV_RESET_PC     32'h0000_0000

// base opcodes of the supported subset
`define RV_OP_R         7'b0110011
`define RV_OP_I         7'b0010011
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_JAL       7'b1101111
`define RV_OP_LUI       7'b0110111

// alu funct3 codes
`define RV_F3_ADDSUB    3'b000
`define RV_F3_SLL       3'b001
`define RV_F3_SLT       3'b010
`define RV_F3_SLTU      3'b011
`define RV_F3_XOR       3'b100
`define RV_F3_SR        3'b101
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111

// memory access widths
`define RV_F3_BYTE      3'b000
`define RV_F3_HALF      3'b001
`define RV_F3_WORD      3'b010
`define RV_F3_BYTEU     3'b100
`define RV_F3_HALFU     3'b101

`endif

// ==== src/rv_pkg.sv ====
`include "rv_macros.svh"

package rv_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, seen through each encoding format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } rv_instr_u;

    // funct3 with the sub/arithmetic bit on top
    typedef enum logic [3:0] {
        alu_add  = {1'b0, `RV_F3_ADDSUB},
        alu_sll  = {1'b0, `RV_F3_SLL},
        alu_slt  = {1'b0, `RV_F3_SLT},
        alu_sltu = {1'b0, `RV_F3_SLTU},
        alu_xor  = {1'b0, `RV_F3_XOR},
        alu_srl  = {1'b0, `RV_F3_SR},
        alu_or   = {1'b0, `RV_F3_OR},
        alu_and  = {1'b0, `RV_F3_AND},
        alu_sub  = {1'b1, `RV_F3_ADDSUB},
        alu_sra  = {1'b1, `RV_F3_SR}
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_alu  = 2'd0,
        wb_mem  = 2'd1,
        wb_link = 2'd2,
        wb_imm  = 2'd3
    } wb_sel_e;

    typedef enum logic [1:0] {
        pc_seq    = 2'd0,
        pc_branch = 2'd1,
        pc_jump   = 2'd2
    } pc_sel_e;

endpackage

// ==== src/rv_ctrl_if.sv ====
`timescale 1ns/1ps
`include "rv_macros.svh"

interface rv_ctrl_if;
    import rv_pkg::*;

    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [2:0]          funct3;
    alu_op_e             alu_op;
    logic                alu_src_imm;
    logic [`RV_XLEN-1:0] imm;
    logic                reg_write;
    wb_sel_e             wb_sel;
    pc_sel_e             pc_sel;
    logic                pc_update;
    logic                instr_fetch;

    modport decode (output rs1, rs2, rd, funct3, alu_op, alu_src_imm, imm,
                    reg_write, wb_sel, pc_sel, pc_update, instr_fetch);
    modport execute (input rs1, rs2, rd, alu_op, alu_src_imm, imm, reg_write);
    modport result (input funct3, imm, wb_sel, pc_sel, pc_update, instr_fetch);

endinterface

// ==== src/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_decode (
    input  logic                Clock,
    input  logic                Reset_L,
    input  logic [`RV_XLEN-1:0] Instruction,
    input  logic                DTAck,
    rv_ctrl_if.decode           ctrl,
    output logic                AS_L,
    output logic                WE_L
);
    import rv_pkg::*;

    typedef enum logic [3:0] {
        st_latch, st_start, st_wb, st_mem_rd, st_mem_wr,
        st_branch, st_jump, st_upper, st_complete, st_settle
    } state_e;

    state_e    state;
    state_e    exec_state;
    rv_instr_u instr;
    logic      writes_rd;
    logic      fetch_q;

    // field positions are shared by all formats that carry them
    assign ctrl.rs1    = instr.r_fmt.rs1;
    assign ctrl.rs2    = instr.r_fmt.rs2;
    assign ctrl.rd     = instr.r_fmt.rd;
    assign ctrl.funct3 = instr.r_fmt.funct3;

    always_comb begin
        ctrl.alu_op      = alu_add;
        ctrl.alu_src_imm = 1'b1;
        ctrl.imm         = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
        ctrl.wb_sel      = wb_alu;
        ctrl.pc_sel      = pc_seq;
        writes_rd        = 1'b0;
        // unknown opcodes fall through write-back with nothing written
        exec_state       = st_wb;
        case (instr.r_fmt.opcode)
            `RV_OP_R: begin
                ctrl.alu_op      = alu_op_e'({instr.r_fmt.funct7[5], instr.r_fmt.funct3});
                ctrl.alu_src_imm = 1'b0;
                writes_rd        = 1'b1;
            end
            `RV_OP_I: begin
                // only srai uses bit 30 of the immediate as an op select
                if (instr.i_fmt.funct3 == `RV_F3_SR) begin
                    ctrl.alu_op = alu_op_e'({instr.r_fmt.funct7[5], instr.i_fmt.funct3});
                end else begin
                    ctrl.alu_op = alu_op_e'({1'b0, instr.i_fmt.funct3});
                end
                writes_rd = 1'b1;
            end
            `RV_OP_LOAD: begin
                ctrl.wb_sel = wb_mem;
                writes_rd   = 1'b1;
                exec_state  = st_mem_rd;
            end
            `RV_OP_STORE: begin
                ctrl.imm   = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                              instr.s_fmt.imm_4_0};
                exec_state = st_mem_wr;
            end
            `RV_OP_BRANCH: begin
                // beq/bne compare through sub, the rest through slt/sltu
                case (instr.b_fmt.funct3[2:1])
                    2'b10:   ctrl.alu_op = alu_slt;
                    2'b11:   ctrl.alu_op = alu_sltu;
                    default: ctrl.alu_op = alu_sub;
                endcase
                ctrl.alu_src_imm = 1'b0;
                ctrl.imm         = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12,
                                    instr.b_fmt.imm_11, instr.b_fmt.imm_10_5,
                                    instr.b_fmt.imm_4_1, 1'b0};
                ctrl.pc_sel      = pc_branch;
                exec_state       = st_branch;
            end
            `RV_OP_JAL: begin
                ctrl.imm    = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20,
                               instr.j_fmt.imm_19_12, instr.j_fmt.imm_11,
                               instr.j_fmt.imm_10_1, 1'b0};
                ctrl.wb_sel = wb_link;
                ctrl.pc_sel = pc_jump;
                writes_rd   = 1'b1;
                exec_state  = st_jump;
            end
            `RV_OP_LUI: begin
                ctrl.imm    = {instr.u_fmt.imm_31_12, 12'h000};
                ctrl.wb_sel = wb_imm;
                writes_rd   = 1'b1;
                exec_state  = st_upper;
            end
            default: ;
        endcase
    end

    // action states each commit once, at the edge that leaves them
    assign ctrl.pc_update   = (state == st_wb) || (state == st_branch) ||
                              (state == st_jump) || (state == st_upper);
    assign ctrl.reg_write   = ctrl.pc_update && writes_rd;
    assign ctrl.instr_fetch = fetch_q;

    always_ff @(posedge Clock) begin
        if (state == st_latch) begin
            instr <= Instruction;
        end
    end

    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            state   <= st_latch;
            AS_L    <= 1'b1;
            WE_L    <= 1'b1;
            fetch_q <= 1'b1;
        end else begin
            case (state)
                st_latch: state <= st_start;
                st_start: begin
                    state <= exec_state;
                    if (exec_state == st_mem_rd || exec_state == st_mem_wr) begin
                        AS_L    <= 1'b0;
                        fetch_q <= 1'b0;
                    end
                    if (exec_state == st_mem_wr) begin
                        WE_L <= 1'b0;
                    end
                end
                // bus cycle held open until the slave answers
                st_mem_rd, st_mem_wr: begin
                    if (DTAck) begin
                        state <= st_wb;
                    end
                end
                st_wb, st_branch, st_jump, st_upper: begin
                    state <= st_complete;
                    AS_L  <= 1'b1;
                    WE_L  <= 1'b1;
                end
                st_complete: begin
                    state   <= st_settle;
                    fetch_q <= 1'b1;
                end
                // memory needs a cycle to present the new word
                st_settle: state <= st_latch;
                default:   state <= st_latch;
            endcase
        end
    end

endmodule

// ==== src/rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_execute (
    input  logic                Clock,
    input  logic                Reset_L,
    rv_ctrl_if.execute          ctrl,
    input  logic [`RV_XLEN-1:0] wr_data,
    output logic [`RV_XLEN-1:0] alu_result,
    output logic [`RV_XLEN-1:0] rs2_data,
    output logic                zero
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] regs [32];
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic                lt_signed;
    logic                lt_unsigned;

    // x0 is never written so it always reads back zero
    assign rs1_data = regs[ctrl.rs1];
    assign rs2_data = regs[ctrl.rs2];

    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_write && ctrl.rd != 5'd0) begin
            regs[ctrl.rd] <= wr_data;
        end
    end

    assign op_b        = ctrl.alu_src_imm ? ctrl.imm : rs2_data;
    assign shamt       = op_b[4:0];
    assign lt_signed   = $signed(rs1_data) < $signed(op_b);
    assign lt_unsigned = rs1_data < op_b;

    always_comb begin
        case (ctrl.alu_op)
            alu_add:  alu_result = rs1_data + op_b;
            alu_sub:  alu_result = rs1_data - op_b;
            alu_sll:  alu_result = rs1_data << shamt;
            alu_slt:  alu_result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            alu_sltu: alu_result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            alu_xor:  alu_result = rs1_data ^ op_b;
            alu_srl:  alu_result = rs1_data >> shamt;
            alu_sra:  alu_result = $signed(rs1_data) >>> shamt;
            alu_or:   alu_result = rs1_data | op_b;
            alu_and:  alu_result = rs1_data & op_b;
            // funct7 bit set on an op without a variant
            default:  alu_result = rs1_data + op_b;
        endcase
    end

    // beq/bne look at this after a subtract
    assign zero = (alu_result == '0);

endmodule

// ==== src/rv_result.sv ====
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_result (
    input  logic                Clock,
    input  logic                Reset_L,
    rv_ctrl_if.result           ctrl,
    input  logic [`RV_XLEN-1:0] alu_result,
    input  logic [`RV_XLEN-1:0] rs2_data,
    input  logic [`RV_XLEN-1:0] DataBus_In,
    input  logic                zero,
    output logic [`RV_XLEN-1:0] wr_data,
    output logic [`RV_XLEN-1:0] Address,
    output logic [`RV_XLEN-1:0] DataBus_Out,
    output logic [3:0]          Byte_Enable
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] pc_target;
    logic [`RV_XLEN-1:0] load_word;
    logic [`RV_XLEN-1:0] load_data;
    logic [1:0]          addr_lo;
    logic                taken;

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + ctrl.imm;

    // funct3[2] picks the compare kind, funct3[0] inverts the test
    always_comb begin
        if (!ctrl.funct3[2]) begin
            taken = ctrl.funct3[0] ? !zero : zero;
        end else begin
            taken = ctrl.funct3[0] ? (alu_result == '0) : (alu_result == 32'd1);
        end
    end

    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            pc <= `RV_RESET_PC;
        end else if (ctrl.pc_update) begin
            case (ctrl.pc_sel)
                pc_jump:   pc <= pc_target;
                pc_branch: pc <= taken ? pc_target : pc_plus4;
                default:   pc <= pc_plus4;
            endcase
        end
    end

    assign Address = ctrl.instr_fetch ? pc : alu_result;
    assign addr_lo = Address[1:0];

    // bring the addressed lane down to bit 0 before extension
    assign load_word = DataBus_In >> {addr_lo, 3'b000};

    always_comb begin
        case (ctrl.funct3)
            `RV_F3_BYTE:  load_data = {{24{load_word[7]}}, load_word[7:0]};
            `RV_F3_HALF:  load_data = {{16{load_word[15]}}, load_word[15:0]};
            `RV_F3_WORD:  load_data = load_word;
            `RV_F3_BYTEU: load_data = {24'h000000, load_word[7:0]};
            `RV_F3_HALFU: load_data = {16'h0000, load_word[15:0]};
            default:      load_data = '0;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            wb_mem:  wr_data = load_data;
            wb_link: wr_data = pc_plus4;
            wb_imm:  wr_data = ctrl.imm;
            default: wr_data = alu_result;
        endcase
    end

    // misaligned half and word accesses enable no lanes
    always_comb begin
        Byte_Enable = 4'b0000;
        DataBus_Out = rs2_data;
        case (ctrl.funct3)
            `RV_F3_BYTE, `RV_F3_BYTEU: begin
                Byte_Enable = 4'b0001 << addr_lo;
                DataBus_Out = {4{rs2_data[7:0]}};
            end
            `RV_F3_HALF, `RV_F3_HALFU: begin
                if (!addr_lo[0]) begin
                    Byte_Enable = 4'b0011 << addr_lo;
                end
                DataBus_Out = {2{rs2_data[15:0]}};
            end
            `RV_F3_WORD: begin
                if (addr_lo == 2'b00) begin
                    Byte_Enable = 4'b1111;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core (
    input  logic                Clock,
    input  logic                Reset_L,
    input  logic                DTAck,
    input  logic [`RV_XLEN-1:0] Instruction,
    input  logic [`RV_XLEN-1:0] DataBus_In,
    output logic                AS_L,
    output logic                WE_L,
    output logic [3:0]          Byte_Enable,
    output logic [`RV_XLEN-1:0] DataBus_Out,
    output logic [`RV_XLEN-1:0] Address
);

    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] wr_data;
    logic                zero;

    rv_ctrl_if ctrl ();

    rv_decode u_decode (
        .Clock       (Clock),
        .Reset_L     (Reset_L),
        .Instruction (Instruction),
        .DTAck       (DTAck),
        .ctrl        (ctrl.decode),
        .AS_L        (AS_L),
        .WE_L        (WE_L)
    );

    rv_execute u_execute (
        .Clock      (Clock),
        .Reset_L    (Reset_L),
        .ctrl       (ctrl.execute),
        .wr_data    (wr_data),
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .zero       (zero)
    );

    rv_result u_result (
        .Clock       (Clock),
        .Reset_L     (Reset_L),
        .ctrl        (ctrl.result),
        .alu_result  (alu_result),
        .rs2_data    (rs2_data),
        .DataBus_In  (DataBus_In),
        .zero        (zero),
        .wr_data     (wr_data),
        .Address     (Address),
        .DataBus_Out (DataBus_Out),
        .Byte_Enable (Byte_Enable)
    );

endmodule

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_rv_core;

    localparam logic [31:0] OPA        = 32'hFFFF_FFEC;
    localparam logic [31:0] OPB        = 32'd3;
    localparam logic [31:0] OPC        = 32'h1234_5678;
    localparam logic [31:0] STORE_BASE = 32'h0000_0400;
    localparam int          WAIT_LIMIT = 100;

    logic        Clock;
    logic        Reset_L;
    logic        DTAck;
    logic [31:0] Instruction;
    logic [31:0] DataBus_In;
    logic        AS_L;
    logic        WE_L;
    logic [3:0]  Byte_Enable;
    logic [31:0] DataBus_Out;
    logic [31:0] Address;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:63];
    logic [31:0] exp_addr [0:63];
    logic [31:0] exp_data [0:63];
    logic [3:0]  exp_be [0:63];
    string       exp_name [0:63];
    int          n_exp;
    int          prog_len;
    int          soff;
    logic [31:0] rng;
    logic [1:0]  ack_delay;
    logic        in_access;
    int          errors;
    int          passed;
    int          failed;

    rv_core uut (
        .Clock       (Clock),
        .Reset_L     (Reset_L),
        .DTAck       (DTAck),
        .Instruction (Instruction),
        .DataBus_In  (DataBus_In),
        .AS_L        (AS_L),
        .WE_L        (WE_L),
        .Byte_Enable (Byte_Enable),
        .DataBus_Out (DataBus_Out),
        .Address     (Address)
    );

    always #50 Clock = ~Clock;

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_R};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, `RV_OP_LUI};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    // a distinct background word for every address
    function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;
    endfunction

    task put(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    // each store gets its own word slot and lane picks the byte inside it
    task store_at(input string name, input logic [2:0] f3, input logic [4:0] rs2,
                  input int lane, input logic [31:0] data, input logic [3:0] be);
        put(s_word(12'(soff + lane), rs2, 5'd10, f3));
        exp_name[n_exp] = name;
        exp_addr[n_exp] = STORE_BASE + soff + lane;
        exp_data[n_exp] = data;
        exp_be[n_exp]   = be;
        n_exp++;
        soff += 4;
    endtask

    task r_op(input string name, input logic [6:0] f7, input logic [2:0] f3,
              input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] expected);
        put(r_word(f7, rs2, rs1, f3, 5'd4));
        store_at(name, `RV_F3_WORD, 5'd4, 0, expected, 4'hF);
    endtask

    task i_op(input string name, input logic [11:0] imm, input logic [2:0] f3,
              input logic [4:0] rs1, input logic [31:0] expected);
        put(i_word(imm, rs1, f3, 5'd4, `RV_OP_I));
        store_at(name, `RV_F3_WORD, 5'd4, 0, expected, 4'hF);
    endtask

    task load_back(input string name, input logic [2:0] f3, input logic [11:0] off,
                   input logic [31:0] expected);
        put(i_word(off, 5'd11, f3, 5'd5, `RV_OP_LOAD));
        store_at(name, `RV_F3_WORD, 5'd5, 0, expected, 4'hF);
    endtask

    // x8 store right after the branch shows up only when it falls through
    task branch_case(input string name, input logic [2:0] f3, input logic [4:0] rs1,
                     input logic [4:0] rs2, input bit taken);
        put(b_word(13'd8, rs2, rs1, f3));
        if (taken) begin
            put(s_word(12'(soff), 5'd8, 5'd10, `RV_F3_WORD));
            soff += 4;
        end else begin
            store_at({name, "_fall"}, `RV_F3_WORD, 5'd8, 0, 32'h0000_02C3, 4'hF);
        end
        store_at({name, "_mark"}, `RV_F3_WORD, 5'd7, 0, 32'h0000_005A, 4'hF);
    endtask

    task build_program;
        logic [31:0] link;
        prog_len = 0;
        soff     = 0;
        n_exp    = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0;
        end
        // operands plus the store base in x10 and the load base in x11
        put(i_word(12'hFEC, 5'd0, `RV_F3_ADDSUB, 5'd1, `RV_OP_I));
        put(i_word(12'd3, 5'd0, `RV_F3_ADDSUB, 5'd2, `RV_OP_I));
        put(u_word(20'h12345, 5'd3));
        put(i_word(12'h678, 5'd3, `RV_F3_ADDSUB, 5'd3, `RV_OP_I));
        put(i_word(12'h400, 5'd0, `RV_F3_ADDSUB, 5'd10, `RV_OP_I));
        put(i_word(12'h200, 5'd0, `RV_F3_ADDSUB, 5'd11, `RV_OP_I));
        put(i_word(12'd3, 5'd0, `RV_F3_ADDSUB, 5'd6, `RV_OP_I));
        put(i_word(12'h05A, 5'd0, `RV_F3_ADDSUB, 5'd7, `RV_OP_I));
        put(i_word(12'h2C3, 5'd0, `RV_F3_ADDSUB, 5'd8, `RV_OP_I));

        r_op("add", 7'h00, `RV_F3_ADDSUB, 5'd1, 5'd2, OPA + OPB);
        r_op("sub", 7'h20, `RV_F3_ADDSUB, 5'd1, 5'd2, OPA - OPB);
        r_op("sll", 7'h00, `RV_F3_SLL, 5'd3, 5'd2, OPC << 3);
        r_op("slt", 7'h00, `RV_F3_SLT, 5'd1, 5'd2, 32'd1);
        r_op("sltu", 7'h00, `RV_F3_SLTU, 5'd1, 5'd2, 32'd0);
        r_op("xor", 7'h00, `RV_F3_XOR, 5'd1, 5'd3, OPA ^ OPC);
        r_op("srl", 7'h00, `RV_F3_SR, 5'd1, 5'd2, OPA >> 3);
        r_op("sra", 7'h20, `RV_F3_SR, 5'd1, 5'd2, $signed(OPA) >>> 3);
        r_op("or", 7'h00, `RV_F3_OR, 5'd1, 5'd3, OPA | OPC);
        r_op("and", 7'h00, `RV_F3_AND, 5'd1, 5'd3, OPA & OPC);

        i_op("addi", 12'd100, `RV_F3_ADDSUB, 5'd1, OPA + 32'd100);
        i_op("slli", 12'd4, `RV_F3_SLL, 5'd3, OPC << 4);
        i_op("slti", 12'hFFB, `RV_F3_SLT, 5'd1, 32'd1);
        i_op("sltiu", 12'hFFB, `RV_F3_SLTU, 5'd1, 32'd1);
        i_op("xori", 12'hFFF, `RV_F3_XOR, 5'd3, ~OPC);
        i_op("srli", 12'd28, `RV_F3_SR, 5'd1, OPA >> 28);
        i_op("srai", 12'h402, `RV_F3_SR, 5'd1, $signed(OPA) >>> 2);
        i_op("ori", 12'h0F0, `RV_F3_OR, 5'd3, OPC | 32'h0F0);
        i_op("andi", 12'h7F0, `RV_F3_AND, 5'd3, OPC & 32'h7F0);

        // 0x200 holds 80F1_7F82 and 0x204 holds 1234_ABCD
        load_back("lb0", `RV_F3_BYTE, 12'd0, 32'hFFFF_FF82);
        load_back("lb1", `RV_F3_BYTE, 12'd1, 32'h0000_007F);
        load_back("lb2", `RV_F3_BYTE, 12'd2, 32'hFFFF_FFF1);
        load_back("lbu3", `RV_F3_BYTEU, 12'd3, 32'h0000_0080);
        load_back("lh0", `RV_F3_HALF, 12'd0, 32'h0000_7F82);
        load_back("lh2", `RV_F3_HALF, 12'd2, 32'hFFFF_80F1);
        load_back("lhu4", `RV_F3_HALFU, 12'd4, 32'h0000_ABCD);
        load_back("lhu6", `RV_F3_HALFU, 12'd6, 32'h0000_1234);
        load_back("lw4", `RV_F3_WORD, 12'd4, 32'h1234_ABCD);

        store_at("sb0", `RV_F3_BYTE, 5'd3, 0, 32'h0000_0078, 4'b0001);
        store_at("sb1", `RV_F3_BYTE, 5'd3, 1, 32'h0000_7800, 4'b0010);
        store_at("sb2", `RV_F3_BYTE, 5'd3, 2, 32'h0078_0000, 4'b0100);
        store_at("sb3", `RV_F3_BYTE, 5'd3, 3, 32'h7800_0000, 4'b1000);
        store_at("sh0", `RV_F3_HALF, 5'd3, 0, 32'h0000_5678, 4'b0011);
        store_at("sh2", `RV_F3_HALF, 5'd3, 2, 32'h5678_0000, 4'b1100);

        branch_case("beq_t", 3'b000, 5'd2, 5'd6, 1'b1);
        branch_case("beq_n", 3'b000, 5'd1, 5'd2, 1'b0);
        branch_case("bne_t", 3'b001, 5'd1, 5'd2, 1'b1);
        branch_case("bne_n", 3'b001, 5'd2, 5'd6, 1'b0);
        branch_case("blt_t", 3'b100, 5'd1, 5'd2, 1'b1);
        branch_case("blt_n", 3'b100, 5'd2, 5'd1, 1'b0);
        branch_case("bge_t", 3'b101, 5'd2, 5'd1, 1'b1);
        branch_case("bge_n", 3'b101, 5'd1, 5'd2, 1'b0);
        branch_case("bltu_t", 3'b110, 5'd2, 5'd1, 1'b1);
        branch_case("bltu_n", 3'b110, 5'd1, 5'd2, 1'b0);
        branch_case("bgeu_t", 3'b111, 5'd1, 5'd2, 1'b1);
        branch_case("bgeu_n", 3'b111, 5'd2, 5'd1, 1'b0);

        // jal skips one store and links to its own address plus 4
        link = prog_len * 4 + 4;
        put(j_word(21'd8, 5'd9));
        put(s_word(12'(soff), 5'd8, 5'd10, `RV_F3_WORD));
        soff += 4;
        store_at("jal", `RV_F3_WORD, 5'd9, 0, link, 4'hF);
        put(u_word(20'hABCDE, 5'd12));
        store_at("lui", `RV_F3_WORD, 5'd12, 0, 32'hABCD_E000, 4'hF);
        put(j_word(21'd0, 5'd0));
    endtask

    task tally(input string name, input logic ok);
        if (ok) begin
            passed++;
            $display("check %-8s passed", name);
        end else begin
            failed++;
            $display("check %-8s had errors", name);
        end
    endtask

    // memory side of the bus with a random DTAck delay per access
    always @(posedge Clock) begin
        #5;
        if (AS_L) begin
            Instruction = imem[Address[9:2]];
            DTAck       = 1'b0;
            in_access   = 1'b0;
        end else begin
            if (!in_access) begin
                in_access = 1'b1;
                rng       = xorshift(rng);
                ack_delay = rng[1:0];
            end else if (ack_delay != 2'd0) begin
                ack_delay = ack_delay - 2'd1;
            end
            DTAck = (ack_delay == 2'd0);
            // read data is valid only while the slave acknowledges
            DataBus_In = DTAck ? dmem[Address[7:2]] : 32'hxxxx_xxxx;
        end
    end

    initial begin : main
        int   cycles;
        int   i;
        logic ok;
        logic timed_out;
        logic acked;
        Clock       = 1'b0;
        Reset_L     = 1'b0;
        DTAck       = 1'b0;
        Instruction = 32'h0;
        DataBus_In  = 32'h0;
        rng         = 32'd53658;
        ack_delay   = 2'd0;
        in_access   = 1'b0;
        errors      = 0;
        passed      = 0;
        failed      = 0;
        build_program();
        for (int k = 0; k < 64; k++) begin
            dmem[k] = fill_pattern(32'h200 + 4 * k);
        end
        dmem[0] = 32'h80F1_7F82;
        dmem[1] = 32'h1234_ABCD;

        ok = 1'b1;
        repeat (5) begin
            @(posedge Clock);
            #1;
            assert (AS_L === 1'b1) else begin
                $display("[FAIL] %0t AS_L expected 1 got %b", $time, AS_L);
                errors++;
                ok = 1'b0;
            end
            assert (WE_L === 1'b1) else begin
                $display("[FAIL] %0t WE_L expected 1 got %b", $time, WE_L);
                errors++;
                ok = 1'b0;
            end
        end
        #4;
        Reset_L = 1'b1;
        #1;
        assert (Address === 32'h0) else begin
            $display("[FAIL] %0t Address expected %h got %h", $time, 32'h0, Address);
            errors++;
            ok = 1'b0;
        end
        tally("reset", ok);

        i         = 0;
        timed_out = 1'b0;
        while (i < n_exp && !timed_out) begin
            ok     = 1'b1;
            cycles = 0;
            while (WE_L !== 1'b0 && cycles < WAIT_LIMIT) begin
                @(negedge Clock);
                cycles++;
            end
            if (WE_L !== 1'b0) begin
                $display("no store for check %s within %0d cycles", exp_name[i], WAIT_LIMIT);
                timed_out = 1'b1;
                ok        = 1'b0;
            end else begin
                assert (Address === exp_addr[i]) else begin
                    $display("[FAIL] %0t Address expected %h got %h",
                             $time, exp_addr[i], Address);
                    errors++;
                    ok = 1'b0;
                end
                assert (Byte_Enable === exp_be[i]) else begin
                    $display("[FAIL] %0t Byte_Enable expected %b got %b",
                             $time, exp_be[i], Byte_Enable);
                    errors++;
                    ok = 1'b0;
                end
                // only enabled lanes carry meaning
                assert ((DataBus_Out & lane_mask(exp_be[i])) ===
                        (exp_data[i] & lane_mask(exp_be[i]))) else begin
                    $display("[FAIL] %0t DataBus_Out expected %h got %h", $time,
                             exp_data[i] & lane_mask(exp_be[i]),
                             DataBus_Out & lane_mask(exp_be[i]));
                    errors++;
                    ok = 1'b0;
                end
                acked  = 1'b0;
                cycles = 0;
                while (WE_L !== 1'b1 && cycles < WAIT_LIMIT) begin
                    acked = acked | (DTAck === 1'b1);
                    @(negedge Clock);
                    cycles++;
                end
                if (WE_L !== 1'b1) begin
                    $display("WE_L stayed low after check %s", exp_name[i]);
                    timed_out = 1'b1;
                    ok        = 1'b0;
                end else begin
                    assert (acked) else begin
                        $display("store for check %s ended before DTAck was given",
                                 exp_name[i]);
                        errors++;
                        ok = 1'b0;
                    end
                end
            end
            tally(exp_name[i], ok);
            i++;
        end

        $display("summary: %0d passed, %0d failed, %0d mismatches", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== rv_core.f ====
+incdir+src
src/rv_pkg.sv
src/rv_ctrl_if.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core.sv
sim/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - src

sources:
  - src/rv_pkg.sv
  - src/rv_ctrl_if.sv
  - src/rv_decode.sv
  - src/rv_execute.sv
  - src/rv_result.sv
  - src/rv_core.sv
  - target: test
    files:
      - sim/tb_rv_core.sv
